//--- common/tsc_pkg.sv
// ################################################
// Timestamp counter shared definitions
// Data widths, TCR bit layout, MSR addresses and
// the per-register write strobe bundle
// ################################################

`default_nettype none

package tsc_pkg;

   // Data and register width
   localparam int dw = 32;

   // Compare field width, sets the TCR layout
   localparam int cnt_dw = 28;

   // TCR layout, top bit down
   typedef struct packed {
      // Reserved, read back as written
      logic              rb1;
      // Pending interrupt
      logic              p;
      // Interrupt enable
      logic              i;
      // Count enable
      logic              en;
      // Compare value against low TSR bits
      logic [cnt_dw-1:0] cnt;
   } tcr_t;

   // MSR select on the software port
   typedef enum logic [1:0] {
      msr_tsr = 2'd0,
      msr_tcr = 2'd1,
      msr_imr = 2'd2,
      msr_irr = 2'd3
   } msr_addr_e;

   // One strobe per writable register
   // IRR is read-only, so no strobe
   typedef struct packed {
      logic tsr_we;
      logic tcr_we;
      logic imr_we;
   } msr_wr_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the timestamp counter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_tsc_top -f verilog.f -Mdir obj_dir -o tb_tsc_top

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/tb_tsc_top +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

//--- source/irq_pic.sv
// ################################################
// Interrupt unit
// Samples request lines into IRR, holds the IMR
// mask and raises one processor interrupt
// ################################################

`default_nettype none

module irq_pic #(
   parameter int nirq = 8
) (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         imr_we,
   input  wire [tsc_pkg::dw-1:0]       wdata,
   input  wire [nirq-1:0]              irq_lines,
   output logic [nirq-1:0]             imr,
   output logic [nirq-1:0]             irr,
   output logic                        cpu_irq
);

   import tsc_pkg::*;

   // Unmasked requests
   logic [nirq-1:0] irq_pend;

   // Raw requests, sampled every edge
   // Line 0 is the timer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         irr <= '0;
      else
         irr <= irq_lines;
   end

   // Mask register, set bit blocks the line
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         imr <= '0;
      else if (imr_we)
         imr <= wdata[nirq-1:0];
   end

   assign irq_pend = irr & ~imr;

   // Any unmasked request
   assign cpu_irq = |irq_pend;

   // Keep the line count within the data word
   initial begin
      if (nirq < 2 || nirq > dw)
         $error("nirq out of range");
   end

endmodule

`default_nettype wire

//--- source/msr_decode.sv
// ################################################
// MSR port decoder
// Turns address and write strobe into per-register
// write enables and selects the read data
// ################################################

`default_nettype none

module msr_decode #(
   parameter int nirq = 8
) (
   input  wire tsc_pkg::msr_addr_e     msr_addr,
   input  wire                         msr_we,
   input  wire [tsc_pkg::dw-1:0]       tsr,
   input  wire tsc_pkg::tcr_t          tcr,
   input  wire [nirq-1:0]              imr,
   input  wire [nirq-1:0]              irr,
   output tsc_pkg::msr_wr_t            wr,
   output logic [tsc_pkg::dw-1:0]      msr_rdata
);

   import tsc_pkg::*;

   // Write strobes, at most one set
   always_comb begin
      wr = '0;
      if (msr_we) begin
         case (msr_addr)
            msr_tsr: wr.tsr_we = 1'b1;
            msr_tcr: wr.tcr_we = 1'b1;
            msr_imr: wr.imr_we = 1'b1;
            // IRR write is ignored
            default: wr = '0;
         endcase
      end
   end

   // Read mux, purely combinational
   always_comb begin
      msr_rdata = '0;
      case (msr_addr)
         msr_tsr: msr_rdata = tsr;
         // Already carries the write bypass
         msr_tcr: msr_rdata = tcr;
         // Mask and request, zero extended
         msr_imr: msr_rdata[nirq-1:0] = imr;
         msr_irr: msr_rdata[nirq-1:0] = irr;
         default: msr_rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- source/tsc_top.sv
// ################################################
// Timestamp counter and interrupt top level
// MSR decoder, TSR counter, TCR control and
// interrupt unit behind one MSR port
// ################################################

`default_nettype none

module tsc_top #(
   parameter int nirq = 8
) (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire tsc_pkg::msr_addr_e     msr_addr,
   input  wire [tsc_pkg::dw-1:0]       msr_wdata,
   input  wire                         msr_we,
   output logic [tsc_pkg::dw-1:0]      msr_rdata,
   input  wire [nirq-2:0]              ext_irq,
   output logic                        cpu_irq
);

   import tsc_pkg::*;

   msr_wr_t          wr;
   logic [dw-1:0]    tsr;
   tcr_t             tcr;
   logic             count_en;
   logic             tsc_irq;
   logic [nirq-1:0]  imr;
   logic [nirq-1:0]  irr;

   msr_decode #(.nirq(nirq)) u_decode (
      .msr_addr(msr_addr), .msr_we(msr_we), .tsr(tsr), .tcr(tcr),
      .imr(imr), .irr(irr), .wr(wr), .msr_rdata(msr_rdata)
   );

   tsc_counter u_counter (
      .clk(clk), .rst_n(rst_n), .tsr_we(wr.tsr_we), .count_en(count_en),
      .wdata(msr_wdata), .tsr(tsr)
   );

   tsc_ctrl u_ctrl (
      .clk(clk), .rst_n(rst_n), .tcr_we(wr.tcr_we), .wdata(msr_wdata),
      .tsr(tsr), .tcr(tcr), .count_en(count_en), .tsc_irq(tsc_irq)
   );

   // Timer on line 0, external lines above
   irq_pic #(.nirq(nirq)) u_pic (
      .clk(clk), .rst_n(rst_n), .imr_we(wr.imr_we), .wdata(msr_wdata),
      .irq_lines({ext_irq, tsc_irq}), .imr(imr), .irr(irr), .cpu_irq(cpu_irq)
   );

endmodule

`default_nettype wire

//--- tsc/tsc_counter.sv
// ################################################
// Timestamp register (TSR)
// Free-running 32-bit counter, software write
// takes priority over the increment
// ################################################

`default_nettype none

module tsc_counter (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         tsr_we,
   input  wire                         count_en,
   input  wire [tsc_pkg::dw-1:0]       wdata,
   output logic [tsc_pkg::dw-1:0]      tsr
);

   import tsc_pkg::*;

   // Next value
   logic [dw-1:0] tsr_nxt;

   // Write first, else count, else hold
   always_comb begin
      tsr_nxt = tsr;
      if (tsr_we)
         tsr_nxt = wdata;
      else if (count_en)
         // Wraps silently at 32 bits
         tsr_nxt = tsr + 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         tsr <= '0;
      else
         tsr <= tsr_nxt;
   end

endmodule

`default_nettype wire

//--- tsc/tsc_ctrl.sv
// ################################################
// Timer control register (TCR)
// Stores compare value and enables, gives a bypassed
// read view and keeps the pending interrupt latch
// ################################################

`default_nettype none

module tsc_ctrl (
   input  wire                         clk,
   input  wire                         rst_n,
   input  wire                         tcr_we,
   input  wire [tsc_pkg::dw-1:0]       wdata,
   input  wire [tsc_pkg::dw-1:0]       tsr,
   output tsc_pkg::tcr_t               tcr,
   output logic                        count_en,
   output logic                        tsc_irq
);

   import tsc_pkg::*;

   tcr_t tcr_wr;
   tcr_t tcr_q;
   logic irq_set;
   logic irq_clr;

   // Incoming word in TCR layout
   assign tcr_wr = tcr_t'(wdata);

   // Stored TCR
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         tcr_q <= '0;
      else if (tcr_we)
         tcr_q <= tcr_wr;
   end

   // Read view: written word during a write,
   // otherwise stored fields with the live pending bit
   always_comb begin
      tcr = tcr_q;
      tcr.p = tsc_irq;
      if (tcr_we)
         tcr = tcr_wr;
   end

   // Enable being written counts as stored
   assign count_en = tcr.en;

   // Match on low TSR bits with interrupt enabled
   assign irq_set = (tsr[cnt_dw-1:0] == tcr.cnt) & tcr.i;
   // Software acknowledge
   assign irq_clr = tcr_we & ~tcr_wr.p;

   // Pending latch, clear wins
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         tsc_irq <= 1'b0;
      else if (irq_clr)
         tsc_irq <= 1'b0;
      else if (irq_set)
         tsc_irq <= 1'b1;
   end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
// ################################################
// Testbench clock and reset
// 40 ns clock, active-low reset held 10 cycles
// ################################################

`default_nettype none

module tb_clkgen #(
   parameter int period_ns  = 40,
   parameter int rst_cycles = 10
) (
   output logic clk,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   // Release on a rising edge
   initial begin
      rst_n = 1'b0;
      repeat (rst_cycles) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

//--- verif/tb_tsc_top.sv
// ################################################
// Timestamp counter testbench
// Directed tests of the MSR port, TSR counting,
// TCR bypass, timer interrupt and PIC masking
// ################################################

`default_nettype none

module tb_tsc_top;

   timeunit 1ns;
   timeprecision 1ps;

   import tsc_pkg::*;

   localparam int nirq = 8;
   localparam int clk_period = 40;
   // Cycle budget of each test, reset included in the first
   localparam int reset_budget = 100;
   localparam int count_budget = 300;
   localparam int bypass_budget = 100;
   localparam int timer_budget = 500;
   localparam int mask_budget = 1000;
   localparam int total_budget = reset_budget + count_budget + bypass_budget
                                 + timer_budget + mask_budget;

   logic              clk;
   logic              rst_n;
   msr_addr_e         msr_addr;
   logic [dw-1:0]     msr_wdata;
   logic              msr_we;
   logic [dw-1:0]     msr_rdata;
   logic [nirq-2:0]   ext_irq;
   logic              cpu_irq;
   int                err_cnt;
   int                fail_tests;

   tb_clkgen #(.period_ns(clk_period), .rst_cycles(10)) u_clkgen (
      .clk(clk), .rst_n(rst_n)
   );

   tsc_top #(.nirq(nirq)) u_dut (
      .clk(clk), .rst_n(rst_n), .msr_addr(msr_addr), .msr_wdata(msr_wdata),
      .msr_we(msr_we), .msr_rdata(msr_rdata), .ext_irq(ext_irq), .cpu_irq(cpu_irq)
   );

   // One MSR cycle, results checked mid-cycle
   task automatic write_reg(input msr_addr_e a, input logic [dw-1:0] d);
      @(posedge clk);
      msr_addr <= a;
      msr_wdata <= d;
      msr_we <= 1'b1;
      @(negedge clk);
   endtask

   task automatic read_reg(input msr_addr_e a);
      @(posedge clk);
      msr_addr <= a;
      msr_we <= 1'b0;
      @(negedge clk);
   endtask

   task automatic compare_word(input string name, input logic [dw-1:0] got,
                               input logic [dw-1:0] exp);
      assert (got === exp) else begin
         $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic expect_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("Error: time %0t %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         fail_tests++;
         $display("test %s: %0d errors", name, err_cnt - errs_before);
      end
   endtask

   // Every MSR zero out of reset
   task automatic reset_values();
      for (int a = 0; a < 4; a++) begin
         read_reg(msr_addr_e'(a));
         compare_word("msr_rdata", msr_rdata, '0);
         expect_bit("cpu_irq", cpu_irq, 1'b0);
      end
   endtask

   // TSR shows x one cycle after the write, then one more per cycle
   task automatic count_and_hold();
      tcr_t          w;
      logic [dw-1:0] x;
      logic [dw-1:0] starts [2];
      starts[0] = $urandom;
      // Crosses the 32-bit wrap
      starts[1] = 32'hffff_fffb;
      w = '0;
      w.en = 1'b1;
      write_reg(msr_tcr, w);
      foreach (starts[s]) begin
         x = starts[s];
         write_reg(msr_tsr, x);
         for (int k = 0; k < 10; k++) begin
            read_reg(msr_tsr);
            compare_word("tsr", msr_rdata, x + k);
         end
      end
      // Counting off, value holds
      write_reg(msr_tcr, '0);
      x = $urandom;
      write_reg(msr_tsr, x);
      for (int k = 0; k < 5; k++) begin
         read_reg(msr_tsr);
         compare_word("tsr", msr_rdata, x);
      end
   endtask

   task automatic tcr_bypass();
      tcr_t w;
      tcr_t stored;
      w = tcr_t'($urandom);
      w.p = 1'b1;
      // No match can set the latch
      w.i = 1'b0;
      write_reg(msr_tcr, w);
      compare_word("tcr", msr_rdata, w);
      // Live latch replaces the written p
      stored = w;
      stored.p = 1'b0;
      read_reg(msr_tcr);
      compare_word("tcr", msr_rdata, stored);
      write_reg(msr_tcr, '0);
      read_reg(msr_tcr);
      compare_word("tcr", msr_rdata, '0);
   endtask

   task automatic timer_interrupt();
      tcr_t          w;
      tcr_t          r;
      logic [dw-1:0] x;
      write_reg(msr_tcr, '0);
      x = $urandom;
      write_reg(msr_tsr, x);
      w = '0;
      w.en = 1'b1;
      w.i = 1'b1;
      w.cnt = x[cnt_dw-1:0] + cnt_dw'(20);
      write_reg(msr_tcr, w);
      expect_bit("cpu_irq", cpu_irq, 1'b0);
      // Match in cycle 20 after the enabling write, latch at 21, IRR at 22
      for (int n = 1; n <= 24; n++) begin
         read_reg(msr_tcr);
         r = msr_rdata;
         expect_bit("tcr.p", r.p, n >= 21);
         expect_bit("cpu_irq", cpu_irq, n >= 22);
      end
      // Acknowledge, w still has p at 0
      write_reg(msr_tcr, w);
      compare_word("tcr", msr_rdata, w);
      expect_bit("cpu_irq", cpu_irq, 1'b1);
      read_reg(msr_tcr);
      r = msr_rdata;
      expect_bit("tcr.p", r.p, 1'b0);
      expect_bit("cpu_irq", cpu_irq, 1'b1);
      read_reg(msr_tcr);
      r = msr_rdata;
      expect_bit("tcr.p", r.p, 1'b0);
      expect_bit("cpu_irq", cpu_irq, 1'b0);
      // Match with i clear stays silent
      write_reg(msr_tcr, '0);
      x = $urandom;
      write_reg(msr_tsr, x);
      w.i = 1'b0;
      w.cnt = x[cnt_dw-1:0] + cnt_dw'(5);
      write_reg(msr_tcr, w);
      for (int n = 1; n <= 12; n++) begin
         read_reg(msr_tcr);
         r = msr_rdata;
         expect_bit("tcr.p", r.p, 1'b0);
         expect_bit("cpu_irq", cpu_irq, 1'b0);
      end
   endtask

   // op bit 0 picks IMR over IRR, bit 1 makes it a write
   task automatic mask_and_lines();
      logic [nirq-2:0] prev_ext;
      logic [nirq-2:0] new_ext;
      logic [nirq-1:0] exp_irr;
      logic [nirq-1:0] exp_imr;
      logic [dw-1:0]   wd;
      int              op;
      write_reg(msr_imr, '0);
      prev_ext = '0;
      exp_imr = '0;
      for (int n = 0; n < 200; n++) begin
         op = $urandom_range(0, 3);
         new_ext = (nirq-1)'($urandom & $urandom);
         wd = $urandom;
         @(posedge clk);
         ext_irq <= new_ext;
         msr_addr <= op[0] ? msr_imr : msr_irr;
         msr_we <= op[1];
         msr_wdata <= wd;
         @(negedge clk);
         // Lines of the previous cycle, timer idle on bit 0
         exp_irr = {prev_ext, 1'b0};
         if (op[0])
            compare_word("imr", msr_rdata, dw'(exp_imr));
         else
            compare_word("irr", msr_rdata, dw'(exp_irr));
         expect_bit("cpu_irq", cpu_irq, |(exp_irr & ~exp_imr));
         if (op == 3)
            exp_imr = wd[nirq-1:0];
         prev_ext = new_ext;
      end
      read_reg(msr_irr);
      compare_word("irr", msr_rdata, dw'({prev_ext, 1'b0}));
   endtask

   initial begin
      int errs_before;
      int total_err;
      msr_addr = msr_tsr;
      msr_wdata = '0;
      msr_we = 1'b0;
      ext_irq = '0;
      err_cnt = 0;
      fail_tests = 0;
      void'($urandom(36));
      wait (rst_n === 1'b1);
      errs_before = err_cnt;
      reset_values();
      report_test("reset values", errs_before);
      errs_before = err_cnt;
      count_and_hold();
      report_test("counting", errs_before);
      errs_before = err_cnt;
      tcr_bypass();
      report_test("tcr bypass", errs_before);
      errs_before = err_cnt;
      timer_interrupt();
      report_test("timer interrupt", errs_before);
      errs_before = err_cnt;
      mask_and_lines();
      report_test("masking and lines", errs_before);
      total_err = err_cnt + u_dut.u_checker.assert_fails;
      $display("tests 5, failed %0d, check errors %0d, assertion failures %0d",
               fail_tests, err_cnt, u_dut.u_checker.assert_fails);
      if (total_err == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   // Watchdog sized from the test budgets
   initial begin
      #(total_budget * clk_period);
      $display("watchdog expired after %0d cycles, tests did not finish", total_budget);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/tsc_checker.sv
// ################################################
// Timer and interrupt unit assertions
// Watches the pending latch of the TCR and the
// processor interrupt of the PIC from the top level
// ################################################

`default_nettype none

module tsc_checker #(
   parameter int nirq = 8
) (
   input wire                          clk,
   input wire                          rst_n,
   input wire                          tcr_we,
   input wire [tsc_pkg::dw-1:0]        wdata,
   input wire [tsc_pkg::dw-1:0]        tsr,
   input wire tsc_pkg::tcr_t           tcr,
   input wire                          tsc_irq,
   input wire [nirq-1:0]               imr,
   input wire [nirq-1:0]               lines,
   input wire                          cpu_irq
);

   timeunit 1ns;
   timeprecision 1ps;

   import tsc_pkg::*;

   // Incoming word in TCR layout
   tcr_t wr_tcr;
   int   assert_fails = 0;

   assign wr_tcr = tcr_t'(wdata);

   // Latch drops only on an acknowledge
   irq_fall_ack: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(tsc_irq) |-> $past(tcr_we && !wr_tcr.p))
   else begin
      $error("timer interrupt cleared without a TCR write with p at 0");
      assert_fails++;
   end

   // Latch rises only after a match with i set
   irq_rise_match: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(tsc_irq) |-> $past((tsr[cnt_dw-1:0] == tcr.cnt) && tcr.i))
   else begin
      $error("timer interrupt set without a compare match and i set");
      assert_fails++;
   end

   // IRR holds the lines of the previous edge
   // No unmasked request there, no processor interrupt
   cpu_irq_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      (($past(lines) & ~imr) == '0) |-> !cpu_irq)
   else begin
      $error("processor interrupt raised with every unmasked request clear");
      assert_fails++;
   end

endmodule

// Top level sees both the TCR latch and the PIC
bind tsc_top tsc_checker #(.nirq(nirq)) u_checker (
   .clk(clk), .rst_n(rst_n), .tcr_we(wr.tcr_we), .wdata(msr_wdata),
   .tsr(tsr), .tcr(tcr), .tsc_irq(tsc_irq), .imr(imr),
   .lines({ext_irq, tsc_irq}), .cpu_irq(cpu_irq)
);

`default_nettype wire

//--- verilog.f
common/tsc_pkg.sv
source/msr_decode.sv
tsc/tsc_counter.sv
tsc/tsc_ctrl.sv
source/irq_pic.sv
source/tsc_top.sv
verif/tb_clkgen.sv
verif/tsc_checker.sv
verif/tb_tsc_top.sv
